/* compile.f */
hw/rv_pkg.sv
hw/pipe_if.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/rv32_core.sv
dv/clock_gen.sv
dv/core_assertions.sv
dv/core_tb.sv

/* dv/core_tb.sv */
`timescale 1ns/10ps

module core_tb;

    logic        clk;
    logic        gen_reset;
    logic        loading;
    logic        core_reset;
    logic        imem_write_enable;
    logic [7:0]  imem_write_address;
    logic [31:0] imem_write_data;
    logic        retire_valid;
    logic [4:0]  retire_rd;
    logic [31:0] retire_data;

    string       names[$];
    logic [31:0] words[$];
    logic [4:0]  exp_rd[$];
    logic [31:0] exp_data[$];
    bit          skipped[$];

    int errors = 0;
    int passed = 0;
    int skip_count = 0;
    int cycles = 0;
    int limit = 0;
    int current_row = 0;

    // Core stays in reset until the program is loaded
    assign core_reset = gen_reset || loading;

    clock_gen #(.period(10), .reset_cycles(3)) clock_gen_i (
        .clk   (clk),
        .reset (gen_reset)
    );

    rv32_core #(.imem_depth(256), .dmem_depth(256)) rv32_core_i (
        .clk                (clk),
        .reset              (core_reset),
        .imem_write_enable  (imem_write_enable),
        .imem_write_address (imem_write_address),
        .imem_write_data    (imem_write_data),
        .retire_valid       (retire_valid),
        .retire_rd          (retire_rd),
        .retire_data        (retire_data)
    );

    bind rv32_core core_assertions assertions_i (
        .clk          (clk),
        .reset        (reset),
        .redirect     (redirect),
        .id_ex_valid  (id_ex.valid),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd)
    );

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opcode);
        return {imm, rs1, f3, rd, opcode};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic add_row(input string name, input logic [31:0] word,
                           input logic [4:0] rd, input logic [31:0] data, input bit skip);
        names.push_back(name);
        words.push_back(word);
        exp_rd.push_back(rd);
        exp_data.push_back(data);
        skipped.push_back(skip);
    endtask

    // x2 = 100, x3 = -7 for most of the ALU rows
    task automatic build_program();
        add_row("lui",       u_type(20'h12345, 1),                     1, 32'h12345000, 0);
        add_row("addi",      i_type(12'd100, 0, 3'b000, 2, 7'h13),     2, 32'h00000064, 0);
        add_row("addi_neg",  i_type(12'hff9, 0, 3'b000, 3, 7'h13),     3, 32'hfffffff9, 0);
        add_row("add_fwd",   r_type(7'h00, 3, 2, 3'b000, 4),           4, 32'h0000005d, 0);
        add_row("sub",       r_type(7'h20, 3, 2, 3'b000, 5),           5, 32'h0000006b, 0);
        add_row("addi_fwd",  i_type(12'd1, 5, 3'b000, 6, 7'h13),       6, 32'h0000006c, 0);
        add_row("slli",      i_type(12'h004, 2, 3'b001, 7, 7'h13),     7, 32'h00000640, 0);
        add_row("srli",      i_type(12'h01c, 3, 3'b101, 8, 7'h13),     8, 32'h0000000f, 0);
        add_row("srai",      i_type(12'h401, 3, 3'b101, 9, 7'h13),     9, 32'hfffffffc, 0);
        add_row("slti",      i_type(12'd0, 3, 3'b010, 10, 7'h13),     10, 32'h00000001, 0);
        add_row("sltiu",     i_type(12'd5, 3, 3'b011, 11, 7'h13),     11, 32'h00000000, 0);
        add_row("xori",      i_type(12'h0ff, 2, 3'b100, 12, 7'h13),   12, 32'h0000009b, 0);
        add_row("ori",       i_type(12'h0f0, 2, 3'b110, 13, 7'h13),   13, 32'h000000f4, 0);
        add_row("andi",      i_type(12'h0f0, 3, 3'b111, 14, 7'h13),   14, 32'h000000f0, 0);
        add_row("addi_amt",  i_type(12'd3, 0, 3'b000, 16, 7'h13),     16, 32'h00000003, 0);
        add_row("sll",       r_type(7'h00, 16, 2, 3'b001, 15),        15, 32'h00000320, 0);
        add_row("srl",       r_type(7'h00, 16, 3, 3'b101, 17),        17, 32'h1fffffff, 0);
        add_row("sra",       r_type(7'h20, 16, 3, 3'b101, 18),        18, 32'hffffffff, 0);
        add_row("slt",       r_type(7'h00, 2, 3, 3'b010, 19),         19, 32'h00000001, 0);
        add_row("sltu",      r_type(7'h00, 2, 3, 3'b011, 20),         20, 32'h00000000, 0);
        add_row("xor",       r_type(7'h00, 3, 2, 3'b100, 21),         21, 32'hffffff9d, 0);
        add_row("or",        r_type(7'h00, 1, 2, 3'b110, 22),         22, 32'h12345064, 0);
        add_row("and",       r_type(7'h00, 3, 1, 3'b111, 23),         23, 32'h12345000, 0);
        add_row("x0_write",  i_type(12'd5, 2, 3'b000, 0, 7'h13),       0, 32'h00000000, 0);
        add_row("x0_read",   r_type(7'h00, 2, 0, 3'b000, 24),         24, 32'h00000064, 0);
        add_row("sw",        s_type(12'd16, 1, 0),                     0, 32'h00000000, 0);
        add_row("lw",        i_type(12'd16, 0, 3'b010, 25, 7'h03),    25, 32'h12345000, 0);
        add_row("load_use",  i_type(12'd1, 25, 3'b000, 26, 7'h13),    26, 32'h12345001, 0);
        add_row("beq_taken", b_type(13'd12, 24, 2, 3'b000),            0, 32'h00000000, 0);
        add_row("beq_skip1", i_type(12'd1, 0, 3'b000, 31, 7'h13),     31, 32'h00000001, 1);
        add_row("beq_skip2", i_type(12'd2, 0, 3'b000, 31, 7'h13),     31, 32'h00000002, 1);
        add_row("bne_not",   b_type(13'd12, 24, 2, 3'b001),            0, 32'h00000000, 0);
        add_row("blt_taken", b_type(13'd12, 2, 3, 3'b100),             0, 32'h00000000, 0);
        add_row("blt_skip1", i_type(12'd3, 0, 3'b000, 31, 7'h13),     31, 32'h00000003, 1);
        add_row("blt_skip2", i_type(12'd4, 0, 3'b000, 31, 7'h13),     31, 32'h00000004, 1);
        add_row("bltu_not",  b_type(13'd12, 2, 3, 3'b110),             0, 32'h00000000, 0);
        add_row("bge_taken", b_type(13'd12, 3, 2, 3'b101),             0, 32'h00000000, 0);
        add_row("bge_skip1", i_type(12'd5, 0, 3'b000, 31, 7'h13),     31, 32'h00000005, 1);
        add_row("bge_skip2", i_type(12'd6, 0, 3'b000, 31, 7'h13),     31, 32'h00000006, 1);
        add_row("bgeu_take", b_type(13'd12, 2, 3, 3'b111),             0, 32'h00000000, 0);
        add_row("bgeu_skp1", i_type(12'd7, 0, 3'b000, 31, 7'h13),     31, 32'h00000007, 1);
        add_row("bgeu_skp2", i_type(12'd8, 0, 3'b000, 31, 7'h13),     31, 32'h00000008, 1);
        add_row("jal",       j_type(21'd12, 29),                      29, 32'h000000ac, 0);
        add_row("jal_skip1", i_type(12'd9, 0, 3'b000, 31, 7'h13),     31, 32'h00000009, 1);
        add_row("jal_skip2", i_type(12'd10, 0, 3'b000, 31, 7'h13),    31, 32'h0000000a, 1);
        add_row("link_use",  i_type(12'd4, 29, 3'b000, 30, 7'h13),    30, 32'h000000b0, 0);
        // Same register in MEM and WB, the newer value must win
        add_row("fwd_old",   i_type(12'd1, 0, 3'b000, 27, 7'h13),     27, 32'h00000001, 0);
        add_row("fwd_new",   i_type(12'd2, 0, 3'b000, 27, 7'h13),     27, 32'h00000002, 0);
        add_row("fwd_prio",  r_type(7'h00, 0, 27, 3'b000, 28),        28, 32'h00000002, 0);
    endtask

    task automatic wait_retire();
        @(negedge clk);
        while (!retire_valid) @(negedge clk);
    endtask

    // Data is only compared for rows that write a register
    task automatic check_row(input int i);
        bit ok;
        ok = 1'b1;
        if (retire_rd !== exp_rd[i]) begin
            $display("MISMATCH %s rd expected x%0d actual x%0d", names[i], exp_rd[i], retire_rd);
            ok = 1'b0;
        end
        if (exp_rd[i] != 5'd0 && retire_data !== exp_data[i]) begin
            $display("MISMATCH %s data expected %h actual %h", names[i], exp_data[i],
                     retire_data);
            ok = 1'b0;
        end
        if (ok) begin
            passed++;
            $display("ok       %s rd=x%0d data=%h", names[i], retire_rd, retire_data);
        end else begin
            errors++;
        end
    endtask

    always @(posedge clk) begin
        if (!core_reset) begin
            cycles++;
            if (cycles > limit) begin
                $display("Timeout after %0d cycles, row %s never retired", cycles,
                         names[current_row]);
                $display("=== FAIL ===");
                $finish;
            end
        end
    end

    initial begin
        loading            = 1'b1;
        imem_write_enable  = 1'b0;
        imem_write_address = '0;
        imem_write_data    = '0;
        build_program();
        limit = 10 * names.size() + 50;

        for (int i = 0; i < names.size(); i++) begin
            @(negedge clk);
            imem_write_enable  = 1'b1;
            imem_write_address = 8'(i);
            imem_write_data    = words[i];
        end
        // Program ends in a jump to itself
        @(negedge clk);
        imem_write_address = 8'(names.size());
        imem_write_data    = j_type(21'd0, 0);
        @(negedge clk);
        imem_write_enable = 1'b0;
        loading           = 1'b0;

        for (int i = 0; i < names.size(); i++) begin
            current_row = i;
            if (skipped[i]) begin
                skip_count++;
                $display("skipped  %s", names[i]);
            end else begin
                wait_retire();
                check_row(i);
            end
        end

        $display("Rows: %0d passed, %0d failed, %0d skipped", passed, errors, skip_count);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* dv/core_assertions.sv */
`timescale 1ns/10ps

module core_assertions (
    input logic       clk,
    input logic       reset,
    input logic       redirect,
    input logic       id_ex_valid,
    input logic       retire_valid,
    input logic [4:0] retire_rd
);

    // Nothing can retire before the pipeline has filled
    property empty_after_reset;
        @(posedge clk) $fell(reset) |-> !retire_valid [*4];
    endproperty

    // Both younger instructions are dropped on a redirect
    property bubble_after_redirect;
        @(posedge clk) disable iff (reset)
            redirect |=> !id_ex_valid [*2];
    endproperty

    property rd_zero_when_idle;
        @(posedge clk) disable iff (reset)
            !retire_valid |-> retire_rd == 5'd0;
    endproperty

    empty_after_reset_check: assert property (empty_after_reset)
        else $error("retire_valid high before the pipeline filled after reset");

    bubble_after_redirect_check: assert property (bubble_after_redirect)
        else $error("ID/EX valid not cleared for two cycles after a redirect");

    rd_zero_when_idle_check: assert property (rd_zero_when_idle)
        else $error("retire_rd nonzero while retire_valid is low");

endmodule

/* dv/clock_gen.sv */
`timescale 1ns/10ps

module clock_gen #(
    parameter int period       = 10,
    parameter int reset_cycles = 3
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

/* hw/rv32_core.sv */
`timescale 1ns/10ps

module rv32_core #(
    parameter int imem_depth = 256,
    parameter int dmem_depth = 256
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          imem_write_enable,
    input  logic [$clog2(imem_depth)-1:0] imem_write_address,
    input  logic [rv_pkg::xlen-1:0]       imem_write_data,
    output logic                          retire_valid,
    output logic [4:0]                    retire_rd,
    output logic [rv_pkg::xlen-1:0]       retire_data
);

    logic [rv_pkg::xlen-1:0] if_pc;
    rv_pkg::instr_t          if_instruction;
    logic                    load_use_stall;
    logic                    redirect;
    logic [rv_pkg::xlen-1:0] redirect_target;

    id_ex_if  id_ex ();
    ex_mem_if ex_mem ();
    fwd_if    fwd ();

    fetch_stage #(.imem_depth(imem_depth)) fetch_i (
        .clk                (clk),
        .reset              (reset),
        .load_use_stall     (load_use_stall),
        .redirect           (redirect),
        .redirect_target    (redirect_target),
        .imem_write_enable  (imem_write_enable),
        .imem_write_address (imem_write_address),
        .imem_write_data    (imem_write_data),
        .if_pc              (if_pc),
        .if_instruction     (if_instruction)
    );

    decode_stage decode_i (
        .clk            (clk),
        .reset          (reset),
        .if_pc          (if_pc),
        .if_instruction (if_instruction),
        .redirect       (redirect),
        .load_use_stall (load_use_stall),
        .id_ex          (id_ex.decode),
        .fwd            (fwd.decode)
    );

    execute_stage execute_i (
        .clk             (clk),
        .reset           (reset),
        .id_ex           (id_ex.execute),
        .fwd             (fwd.execute),
        .ex_mem          (ex_mem.execute),
        .redirect        (redirect),
        .redirect_target (redirect_target)
    );

    memory_stage #(.dmem_depth(dmem_depth)) memory_i (
        .clk          (clk),
        .reset        (reset),
        .ex_mem       (ex_mem.memory),
        .fwd          (fwd.memory),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

endmodule

/* hw/memory_stage.sv */
`timescale 1ns/10ps

module memory_stage #(
    parameter int dmem_depth = 256
) (
    input  logic                    clk,
    input  logic                    reset,
    ex_mem_if.memory                ex_mem,
    fwd_if.memory                   fwd,
    output logic                    retire_valid,
    output logic [4:0]              retire_rd,
    output logic [rv_pkg::xlen-1:0] retire_data
);

    localparam int aw = $clog2(dmem_depth);

    logic [rv_pkg::xlen-1:0] dmem [dmem_depth];
    logic [aw-1:0]           dmem_index;
    logic                    wb_valid;
    logic [rv_pkg::xlen-1:0] wb_result;
    logic [rv_pkg::xlen-1:0] wb_load_data;
    logic [4:0]              wb_rd;
    logic                    wb_reg_write;
    logic [1:0]              wb_sel;

    // Word addressed, low two bits ignored
    assign dmem_index = ex_mem.result[aw+1:2];

    always_ff @(posedge clk) begin
        if (ex_mem.valid && ex_mem.mem_write) begin
            dmem[dmem_index] <= ex_mem.store_data;
        end
    end

    // A load result is not ready until writeback
    assign fwd.mem_write_enable = ex_mem.valid && ex_mem.reg_write && !ex_mem.mem_read &&
                                  ex_mem.rd != 5'd0;
    assign fwd.mem_rd           = ex_mem.rd;
    assign fwd.mem_result       = ex_mem.result;

    // MEM/WB register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= ex_mem.valid;
        end
    end

    always_ff @(posedge clk) begin
        wb_result    <= ex_mem.result;
        wb_load_data <= dmem[dmem_index];
        wb_rd        <= ex_mem.rd;
        wb_reg_write <= ex_mem.reg_write;
        wb_sel       <= ex_mem.wb_sel;
    end

    // Writeback select
    assign fwd.wb_data = (wb_sel == rv_pkg::wb_sel_load) ? wb_load_data : wb_result;
    assign fwd.wb_rd   = wb_rd;
    assign fwd.wb_write_enable = wb_valid && wb_reg_write && wb_rd != 5'd0;

    assign retire_valid = wb_valid;
    assign retire_rd    = (wb_valid && wb_reg_write) ? wb_rd : 5'd0;
    assign retire_data  = fwd.wb_data;

endmodule

/* hw/execute_stage.sv */
`timescale 1ns/10ps

module execute_stage (
    input  logic                    clk,
    input  logic                    reset,
    id_ex_if.execute                id_ex,
    fwd_if.execute                  fwd,
    ex_mem_if.execute               ex_mem,
    output logic                    redirect,
    output logic [rv_pkg::xlen-1:0] redirect_target
);

    logic [rv_pkg::xlen-1:0] op_a;
    logic [rv_pkg::xlen-1:0] op_b;
    logic [rv_pkg::xlen-1:0] src_a;
    logic [rv_pkg::xlen-1:0] src_b;
    logic [rv_pkg::xlen-1:0] alu_result;
    logic                    taken;

    // MEM result is younger, so it is checked first
    function automatic logic [rv_pkg::xlen-1:0] forward(
        input logic [4:0]              rs,
        input logic [rv_pkg::xlen-1:0] reg_data
    );
        if (fwd.mem_write_enable && fwd.mem_rd == rs) return fwd.mem_result;
        if (fwd.wb_write_enable && fwd.wb_rd == rs) return fwd.wb_data;
        return reg_data;
    endfunction

    always_comb begin
        op_a  = forward(id_ex.rs1, id_ex.rs1_data);
        op_b  = forward(id_ex.rs2, id_ex.rs2_data);
        src_a = id_ex.src_a_pc ? id_ex.pc : op_a;
        src_b = id_ex.src_b_imm ? id_ex.imm : op_b;
    end

    always_comb begin
        case (id_ex.alu_op)
            rv_pkg::alu_sub:    alu_result = src_a - src_b;
            rv_pkg::alu_sll:    alu_result = src_a << src_b[4:0];
            rv_pkg::alu_slt:    alu_result = {31'b0, $signed(src_a) < $signed(src_b)};
            rv_pkg::alu_sltu:   alu_result = {31'b0, src_a < src_b};
            rv_pkg::alu_xor:    alu_result = src_a ^ src_b;
            rv_pkg::alu_srl:    alu_result = src_a >> src_b[4:0];
            rv_pkg::alu_sra:    alu_result = $signed(src_a) >>> src_b[4:0];
            rv_pkg::alu_or:     alu_result = src_a | src_b;
            rv_pkg::alu_and:    alu_result = src_a & src_b;
            rv_pkg::alu_pass_b: alu_result = src_b;
            default:            alu_result = src_a + src_b;
        endcase
    end

    always_comb begin
        case (id_ex.funct3)
            3'b000:  taken = op_a == op_b;
            3'b001:  taken = op_a != op_b;
            3'b100:  taken = $signed(op_a) < $signed(op_b);
            3'b101:  taken = $signed(op_a) >= $signed(op_b);
            3'b110:  taken = op_a < op_b;
            3'b111:  taken = op_a >= op_b;
            default: taken = 1'b0;
        endcase
    end

    // Static not-taken, so any taken control transfer redirects
    assign redirect        = id_ex.valid && (id_ex.is_jal || (id_ex.is_branch && taken));
    assign redirect_target = id_ex.pc + id_ex.imm;

    // EX/MEM register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ex_mem.valid <= 1'b0;
        end else begin
            ex_mem.valid <= id_ex.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (id_ex.wb_sel == rv_pkg::wb_sel_link) begin
            ex_mem.result <= id_ex.pc + 32'd4;
        end else begin
            ex_mem.result <= alu_result;
        end
        ex_mem.store_data <= op_b;
        ex_mem.rd         <= id_ex.rd;
        ex_mem.reg_write  <= id_ex.reg_write;
        ex_mem.mem_read   <= id_ex.mem_read;
        ex_mem.mem_write  <= id_ex.mem_write;
        ex_mem.wb_sel     <= id_ex.wb_sel;
    end

endmodule

/* hw/decode_stage.sv */
`timescale 1ns/10ps

module decode_stage (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [rv_pkg::xlen-1:0] if_pc,
    input  rv_pkg::instr_t          if_instruction,
    input  logic                    redirect,
    output logic                    load_use_stall,
    id_ex_if.decode                 id_ex,
    fwd_if.decode                   fwd
);

    rv_pkg::reg_fields_t     rv;
    rv_pkg::imm_fields_t     iv;
    logic [rv_pkg::xlen-1:0] regs [32];
    logic [rv_pkg::xlen-1:0] rs1_data;
    logic [rv_pkg::xlen-1:0] rs2_data;
    logic [rv_pkg::xlen-1:0] imm;
    logic [3:0]              alu_op;
    logic [1:0]              wb_sel;
    logic src_a_pc, src_b_imm, is_branch, is_jal;
    logic reg_write, mem_read, mem_write, use_rs1, use_rs2;

    function automatic logic [3:0] alu_select(input logic [2:0] funct3, input logic alt);
        case (funct3)
            3'b000:  return alt ? rv_pkg::alu_sub : rv_pkg::alu_add;
            3'b001:  return rv_pkg::alu_sll;
            3'b010:  return rv_pkg::alu_slt;
            3'b011:  return rv_pkg::alu_sltu;
            3'b100:  return rv_pkg::alu_xor;
            3'b101:  return alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
            3'b110:  return rv_pkg::alu_or;
            default: return rv_pkg::alu_and;
        endcase
    endfunction

    // Write-through read so WB and ID can share a cycle
    function automatic logic [rv_pkg::xlen-1:0] read_reg(input logic [4:0] rs);
        if (rs == 5'd0) return '0;
        if (fwd.wb_write_enable && fwd.wb_rd == rs) return fwd.wb_data;
        return regs[rs];
    endfunction

    assign rv = if_instruction.r;
    assign iv = if_instruction.raw;

    always_comb begin
        rs1_data = read_reg(rv.rs1);
        rs2_data = read_reg(rv.rs2);
    end

    always_comb begin
        alu_op    = rv_pkg::alu_add;
        wb_sel    = rv_pkg::wb_sel_alu;
        imm       = {{20{iv.imm_hi[6]}}, iv.imm_hi, iv.imm_mid[12:8]};
        src_a_pc  = 1'b0;
        src_b_imm = 1'b1;
        is_branch = 1'b0;
        is_jal    = 1'b0;
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        use_rs1   = 1'b1;
        use_rs2   = 1'b0;
        case (rv.opcode)
            rv_pkg::op_lui: begin
                imm       = {iv.imm_hi, iv.imm_mid, 12'b0};
                alu_op    = rv_pkg::alu_pass_b;
                reg_write = 1'b1;
                use_rs1   = 1'b0;
            end
            rv_pkg::op_jal: begin
                imm       = {{12{iv.imm_hi[6]}}, iv.imm_mid[7:0], iv.imm_mid[8],
                             iv.imm_hi[5:0], iv.imm_mid[12:9], 1'b0};
                src_a_pc  = 1'b1;
                is_jal    = 1'b1;
                reg_write = 1'b1;
                wb_sel    = rv_pkg::wb_sel_link;
                use_rs1   = 1'b0;
            end
            rv_pkg::op_branch: begin
                imm       = {{20{iv.imm_hi[6]}}, iv.imm_lo[0], iv.imm_hi[5:0],
                             iv.imm_lo[4:1], 1'b0};
                src_b_imm = 1'b0;
                is_branch = 1'b1;
                use_rs2   = 1'b1;
            end
            rv_pkg::op_load: begin
                reg_write = 1'b1;
                mem_read  = 1'b1;
                wb_sel    = rv_pkg::wb_sel_load;
            end
            rv_pkg::op_store: begin
                imm       = {{20{iv.imm_hi[6]}}, iv.imm_hi, iv.imm_lo};
                mem_write = 1'b1;
                use_rs2   = 1'b1;
            end
            rv_pkg::op_imm: begin
                // funct7 bit only selects srai here
                alu_op    = alu_select(rv.funct3, rv.funct7[5] && rv.funct3 == 3'b101);
                reg_write = 1'b1;
            end
            rv_pkg::op_reg: begin
                alu_op    = alu_select(rv.funct3, rv.funct7[5]);
                src_b_imm = 1'b0;
                reg_write = 1'b1;
                use_rs2   = 1'b1;
            end
            default: begin
            end
        endcase
    end

    assign load_use_stall = id_ex.valid && id_ex.mem_read && id_ex.rd != 5'd0 &&
                            ((use_rs1 && id_ex.rd == rv.rs1) ||
                             (use_rs2 && id_ex.rd == rv.rs2));

    always_ff @(posedge clk) begin
        if (fwd.wb_write_enable) begin
            regs[fwd.wb_rd] <= fwd.wb_data;
        end
    end

    // ID/EX register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            id_ex.valid <= 1'b0;
        end else begin
            id_ex.valid <= if_instruction != rv_pkg::nop_instruction &&
                           !redirect && !load_use_stall;
        end
    end

    always_ff @(posedge clk) begin
        id_ex.pc        <= if_pc;
        id_ex.rs1       <= rv.rs1;
        id_ex.rs2       <= rv.rs2;
        id_ex.rd        <= rv.rd;
        id_ex.rs1_data  <= rs1_data;
        id_ex.rs2_data  <= rs2_data;
        id_ex.imm       <= imm;
        id_ex.alu_op    <= alu_op;
        id_ex.src_a_pc  <= src_a_pc;
        id_ex.src_b_imm <= src_b_imm;
        id_ex.is_branch <= is_branch;
        id_ex.is_jal    <= is_jal;
        id_ex.funct3    <= rv.funct3;
        id_ex.reg_write <= reg_write;
        id_ex.mem_read  <= mem_read;
        id_ex.mem_write <= mem_write;
        id_ex.wb_sel    <= wb_sel;
    end

endmodule

/* hw/fetch_stage.sv */
`timescale 1ns/10ps

module fetch_stage #(
    parameter int imem_depth = 256
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          load_use_stall,
    input  logic                          redirect,
    input  logic [rv_pkg::xlen-1:0]       redirect_target,
    input  logic                          imem_write_enable,
    input  logic [$clog2(imem_depth)-1:0] imem_write_address,
    input  logic [rv_pkg::xlen-1:0]       imem_write_data,
    output logic [rv_pkg::xlen-1:0]       if_pc,
    output rv_pkg::instr_t                if_instruction
);

    localparam int aw = $clog2(imem_depth);

    logic [rv_pkg::xlen-1:0] pc;
    logic [rv_pkg::xlen-1:0] imem [imem_depth];

    always_ff @(posedge clk) begin
        if (imem_write_enable) begin
            imem[imem_write_address] <= imem_write_data;
        end
    end

    // Redirect wins over the load-use stall
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= '0;
        end else if (redirect) begin
            pc <= redirect_target;
        end else if (!load_use_stall) begin
            pc <= pc + 32'd4;
        end
    end

    // IF/ID register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            if_pc          <= '0;
            if_instruction <= rv_pkg::nop_instruction;
        end else if (redirect) begin
            if_instruction <= rv_pkg::nop_instruction;
        end else if (!load_use_stall) begin
            if_pc          <= pc;
            if_instruction <= imem[pc[aw+1:2]];
        end
    end

endmodule

/* hw/pipe_if.sv */
`timescale 1ns/10ps

interface id_ex_if;
    logic                    valid;
    logic [rv_pkg::xlen-1:0] pc;
    logic [4:0]              rs1;
    logic [4:0]              rs2;
    logic [4:0]              rd;
    logic [rv_pkg::xlen-1:0] rs1_data;
    logic [rv_pkg::xlen-1:0] rs2_data;
    logic [rv_pkg::xlen-1:0] imm;
    logic [3:0]              alu_op;
    logic                    src_a_pc;
    logic                    src_b_imm;
    logic                    is_branch;
    logic                    is_jal;
    logic [2:0]              funct3;
    logic                    reg_write;
    logic                    mem_read;
    logic                    mem_write;
    logic [1:0]              wb_sel;

    modport decode (output valid, pc, rs1, rs2, rd, rs1_data, rs2_data, imm, alu_op,
                    src_a_pc, src_b_imm, is_branch, is_jal, funct3, reg_write, mem_read,
                    mem_write, wb_sel);
    modport execute (input valid, pc, rs1, rs2, rd, rs1_data, rs2_data, imm, alu_op,
                     src_a_pc, src_b_imm, is_branch, is_jal, funct3, reg_write, mem_read,
                     mem_write, wb_sel);
endinterface

interface ex_mem_if;
    logic                    valid;
    logic [rv_pkg::xlen-1:0] result;
    logic [rv_pkg::xlen-1:0] store_data;
    logic [4:0]              rd;
    logic                    reg_write;
    logic                    mem_read;
    logic                    mem_write;
    logic [1:0]              wb_sel;

    modport execute (output valid, result, store_data, rd, reg_write, mem_read, mem_write,
                     wb_sel);
    modport memory (input valid, result, store_data, rd, reg_write, mem_read, mem_write,
                    wb_sel);
endinterface

interface fwd_if;
    logic                    mem_write_enable;
    logic [4:0]              mem_rd;
    logic [rv_pkg::xlen-1:0] mem_result;
    logic                    wb_write_enable;
    logic [4:0]              wb_rd;
    logic [rv_pkg::xlen-1:0] wb_data;

    modport memory (output mem_write_enable, mem_rd, mem_result, wb_write_enable, wb_rd,
                    wb_data);
    modport execute (input mem_write_enable, mem_rd, mem_result, wb_write_enable, wb_rd,
                     wb_data);
    modport decode (input wb_write_enable, wb_rd, wb_data);
endinterface

/* hw/rv_pkg.sv */
package rv_pkg;

    parameter int xlen = 32;

    // Major opcodes
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;

    localparam logic [3:0] alu_add    = 4'd0;
    localparam logic [3:0] alu_sub    = 4'd1;
    localparam logic [3:0] alu_sll    = 4'd2;
    localparam logic [3:0] alu_slt    = 4'd3;
    localparam logic [3:0] alu_sltu   = 4'd4;
    localparam logic [3:0] alu_xor    = 4'd5;
    localparam logic [3:0] alu_srl    = 4'd6;
    localparam logic [3:0] alu_sra    = 4'd7;
    localparam logic [3:0] alu_or     = 4'd8;
    localparam logic [3:0] alu_and    = 4'd9;
    localparam logic [3:0] alu_pass_b = 4'd10;

    localparam logic [1:0] wb_sel_alu  = 2'd0;
    localparam logic [1:0] wb_sel_load = 2'd1;
    localparam logic [1:0] wb_sel_link = 2'd2;

    // addi x0, x0, 0
    localparam logic [31:0] nop_instruction = 32'h0000_0013;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } reg_fields_t;

    // Raw immediate slices, shared by the S, B, U and J formats
    typedef struct packed {
        logic [6:0]  imm_hi;
        logic [12:0] imm_mid;
        logic [4:0]  imm_lo;
        logic [6:0]  opcode;
    } imm_fields_t;

    typedef union packed {
        reg_fields_t r;
        imm_fields_t raw;
    } instr_t;

endpackage
